// ==== common/wrTranCtrl_cfg.svh ====
/*
 * Write-transfer controller configuration
 * Field widths and the AXI burst-length limit of each priority level
 */
`ifndef WRTRANCTRL_CFG_SVH
`define WRTRANCTRL_CFG_SVH

// Field widths
`define ADDR_WIDTH          32
`define TRAN_SIZE_WIDTH     23
// One read never crosses 4 KB
`define AXI_TRAN_SIZE_WIDTH 13
`define NUM_BEATS_WIDTH     8

// One-hot priority levels
`define NUM_PRI_LVLS        8

// Burst-length limit per priority, highest priority first
`define PRI0_BEATS          255
`define PRI1_BEATS          127
`define PRI2_BEATS          63
`define PRI3_BEATS          31
`define PRI4_BEATS          15
`define PRI5_BEATS          7
`define PRI6_BEATS          3
`define PRI7_BEATS          0

`endif

// ==== common/dmaDescPkg.sv ====
/*
 * DMA descriptor types
 * Fields of a queued descriptor as seen by the write side
 */
`default_nettype none

`include "wrTranCtrl_cfg.svh"

package dmaDescPkg;

    // Byte address on the AXI bus
    typedef logic [`ADDR_WIDTH-1:0] addrT;

    // Byte count of a whole descriptor
    typedef logic [`TRAN_SIZE_WIDTH-1:0] tranSizeT;

    // Byte count of one read, at most 4 KB
    typedef logic [`AXI_TRAN_SIZE_WIDTH-1:0] axiTranSizeT;

    // AXI data-width code
    typedef logic [2:0] dataWidthT;

    // One bit per priority level, bit 0 is the highest
    typedef logic [`NUM_PRI_LVLS-1:0] priLvlT;

    // Destination operation, the write types go to the AXI master as they are
    typedef enum logic [1:0]
    {
        DST_NOP   = 2'd0,
        DST_INCR  = 2'd1,
        DST_FIXED = 2'd2,
        DST_RSVD  = 2'd3
    } dstOpT;

endpackage

`default_nettype wire

// ==== common/wrCtrlPkg.sv ====
/*
 * Write controller types
 * Burst-length limit and the descriptor sequencer states
 */
`default_nettype none

`include "wrTranCtrl_cfg.svh"

package wrCtrlPkg;

    // Maximum beats of one AXI burst
    typedef logic [`NUM_BEATS_WIDTH-1:0] numBeatsT;

    // One-hot state encoding
    typedef enum logic [8:0]
    {
        IDLE               = 9'b000000001,
        WAIT_STR_DONE      = 9'b000000010,
        WAIT_DMA_DONE      = 9'b000000100,
        WAIT_STR_DONE_ACK  = 9'b000001000,
        WAIT_STR_ERROR_ACK = 9'b000010000,
        WAIT_DONE_ACK      = 9'b000100000,
        WAIT_ERROR_ACK     = 9'b001000000,
        WAIT_STR_FETCH     = 9'b010000000,
        WAIT_NOP_ACK       = 9'b100000000
    } wrStateT;

endpackage

`default_nettype wire

// ==== hw/wrSequencer/wrSequencer.sv ====
/*
 * Write descriptor sequencer
 * Picks the no-op, stream or memory-write path for the queued descriptor,
 * fetches the stream valid bit and holds the result flags until acked
 */
`timescale 1ns/1ps
`default_nettype none

module wrSequencer
    import dmaDescPkg::*;
    import wrCtrlPkg::*;
(
    input  logic  clock,
    input  logic  resetn,

    input  logic  reqInQueue,
    input  dstOpT dstOp,
    input  logic  strDscrptr,
    input  logic  dataValid,
    input  addrT  extDscrptrAddr,
    input  logic  rdSizeValid,

    input  logic  wrTranDone,
    input  logic  wrTranError,
    input  logic  strWrTranDone,
    input  logic  strWrTranError,
    input  logic  strFetchAck,
    input  logic  strDataValid,

    input  logic  wrDoneAck,
    input  logic  wrErrorAck,
    input  logic  strWrDoneAck,
    input  logic  strWrErrorAck,
    input  logic  noOpDstAck,

    output logic  launchDma,
    output logic  launchStream,
    output logic  strFetchRdy,
    output addrT  strFetchAddr,
    output logic  strDataNReady,
    output logic  noOpDst,
    output logic  wrDone,
    output logic  wrError,
    output logic  strWrDone,
    output logic  strWrError
);

    wrStateT currState;
    wrStateT nextState;

    // Next values of the registered outputs
    logic noOpDstNext;
    logic wrDoneNext;
    logic wrErrorNext;
    logic strWrDoneNext;
    logic strWrErrorNext;
    logic strDataNReadyNext;

    //////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            currState <= IDLE;
        else
            currState <= nextState;
    end

    //////////////////////////////////////////////////
    // Next state, launch strobes and fetch request
    //////////////////////////////////////////////////
    always_comb
    begin
        nextState         = currState;
        launchDma         = 1'b0;
        launchStream      = 1'b0;
        strFetchRdy       = 1'b0;
        strFetchAddr      = '0;
        noOpDstNext       = 1'b0;
        wrDoneNext        = 1'b0;
        wrErrorNext       = 1'b0;
        strWrDoneNext     = 1'b0;
        strWrErrorNext    = 1'b0;
        strDataNReadyNext = 1'b0;

        case (currState)
            IDLE:
            begin
                if (reqInQueue)
                begin
                    if (dstOp == DST_NOP)
                    begin
                        noOpDstNext = 1'b1;
                        nextState   = WAIT_NOP_ACK;
                    end
                    else if (strDscrptr)
                    begin
                        if (dataValid)
                        begin
                            launchStream = 1'b1;
                            nextState    = WAIT_STR_DONE;
                        end
                        else
                        begin
                            // Valid bit lives in the external descriptor
                            strFetchRdy  = 1'b1;
                            strFetchAddr = extDscrptrAddr;
                            nextState    = WAIT_STR_FETCH;
                        end
                    end
                    else if (rdSizeValid)
                    begin
                        // Write size is known only once the read side reports it
                        launchDma = 1'b1;
                        nextState = WAIT_DMA_DONE;
                    end
                end
            end

            WAIT_STR_FETCH:
            begin
                if (strFetchAck)
                begin
                    if (strDataValid)
                    begin
                        launchStream = 1'b1;
                        nextState    = WAIT_STR_DONE;
                    end
                    else
                    begin
                        strDataNReadyNext = 1'b1;
                        nextState         = IDLE;
                    end
                end
                else
                begin
                    strFetchRdy  = 1'b1;
                    strFetchAddr = extDscrptrAddr;
                end
            end

            WAIT_NOP_ACK:
            begin
                if (noOpDstAck)
                    nextState = IDLE;
                else
                    noOpDstNext = 1'b1;
            end

            WAIT_STR_DONE:
            begin
                if (strWrTranDone)
                begin
                    strWrDoneNext = 1'b1;
                    nextState     = WAIT_STR_DONE_ACK;
                end
                else if (strWrTranError)
                begin
                    strWrErrorNext = 1'b1;
                    nextState      = WAIT_STR_ERROR_ACK;
                end
            end

            WAIT_DMA_DONE:
            begin
                if (wrTranDone)
                begin
                    wrDoneNext = 1'b1;
                    nextState  = WAIT_DONE_ACK;
                end
                else if (wrTranError)
                begin
                    wrErrorNext = 1'b1;
                    nextState   = WAIT_ERROR_ACK;
                end
            end

            // Flags stay up until the interrupt block acks them
            WAIT_STR_DONE_ACK:
            begin
                if (strWrDoneAck)
                    nextState = IDLE;
                else
                    strWrDoneNext = 1'b1;
            end

            WAIT_STR_ERROR_ACK:
            begin
                if (strWrErrorAck)
                    nextState = IDLE;
                else
                    strWrErrorNext = 1'b1;
            end

            WAIT_DONE_ACK:
            begin
                if (wrDoneAck)
                    nextState = IDLE;
                else
                    wrDoneNext = 1'b1;
            end

            WAIT_ERROR_ACK:
            begin
                if (wrErrorAck)
                    nextState = IDLE;
                else
                    wrErrorNext = 1'b1;
            end

            default:
            begin
                nextState = IDLE;
            end
        endcase
    end

    // Status flags and not-ready pulse
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            noOpDst       <= 1'b0;
            wrDone        <= 1'b0;
            wrError       <= 1'b0;
            strWrDone     <= 1'b0;
            strWrError    <= 1'b0;
            strDataNReady <= 1'b0;
        end
        else
        begin
            noOpDst       <= noOpDstNext;
            wrDone        <= wrDoneNext;
            wrError       <= wrErrorNext;
            strWrDone     <= strWrDoneNext;
            strWrError    <= strWrErrorNext;
            strDataNReady <= strDataNReadyNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/burstLimit.sv ====
/*
 * Burst-length limiter
 * Maps the descriptor priority to an AXI burst-length limit and holds
 * it from one launch to the next
 */
`timescale 1ns/1ps
`default_nettype none

`include "wrTranCtrl_cfg.svh"

module burstLimit
    import dmaDescPkg::*;
    import wrCtrlPkg::*;
(
    input  logic     clock,
    input  logic     resetn,
    input  logic     launchDma,
    input  logic     launchStream,
    input  priLvlT   priLvl,
    output numBeatsT dstMaxAXINumBeats
);

    localparam numBeatsT BEAT_TABLE [`NUM_PRI_LVLS] = '{
        `PRI0_BEATS, `PRI1_BEATS, `PRI2_BEATS, `PRI3_BEATS,
        `PRI4_BEATS, `PRI5_BEATS, `PRI6_BEATS, `PRI7_BEATS
    };

    numBeatsT priBeats;

    // Anything but a single set bit falls to the lowest priority
    always_comb
    begin
        priBeats = BEAT_TABLE[`NUM_PRI_LVLS-1];
        for (int lvl = 0; lvl < `NUM_PRI_LVLS; lvl++)
        begin
            if (priLvl == (priLvlT'(1) << lvl))
                priBeats = BEAT_TABLE[lvl];
        end
    end

    // Streams always run at the top priority limit
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            dstMaxAXINumBeats <= '0;
        else if (launchStream)
            dstMaxAXINumBeats <= BEAT_TABLE[0];
        else if (launchDma)
            dstMaxAXINumBeats <= priBeats;
    end

endmodule

`default_nettype wire

// ==== hw/wrLaunch.sv ====
/*
 * Write launch register
 * Captures the launch fields for the AXI master for one cycle
 * on a memory-write or stream strobe
 */
`timescale 1ns/1ps
`default_nettype none

`include "wrTranCtrl_cfg.svh"

module wrLaunch
    import dmaDescPkg::*;
(
    input  logic        clock,
    input  logic        resetn,
    input  logic        launchDma,
    input  logic        launchStream,
    input  tranSizeT    numOfBytes,
    input  axiTranSizeT rdSize,
    input  addrT        dstAddr,
    input  dstOpT       dstOp,
    input  dataWidthT   srcDataWidth,
    input  dataWidthT   dstDataWidth,

    output logic        strtAXIWrTran,
    output addrT        dstStrtAddr,
    output dstOpT       dstAXITranType,
    output dataWidthT   dstAXIDataWidth,
    output dataWidthT   srcAXIDataWidth,
    output tranSizeT    numOfBytesInRd,
    output logic        dstStrDscrptr
);

    // Read size padded up to a descriptor byte count
    tranSizeT rdSizeExt;

    assign rdSizeExt = {{(`TRAN_SIZE_WIDTH - `AXI_TRAN_SIZE_WIDTH){1'b0}}, rdSize};

    //////////////////////////////////////////////////
    // Launch fields, valid only in the launch cycle
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            strtAXIWrTran   <= 1'b0;
            dstStrtAddr     <= '0;
            dstAXITranType  <= DST_NOP;
            dstAXIDataWidth <= '0;
            srcAXIDataWidth <= '0;
            numOfBytesInRd  <= '0;
            dstStrDscrptr   <= 1'b0;
        end
        else if (launchDma)
        begin
            strtAXIWrTran   <= 1'b1;
            dstStrtAddr     <= dstAddr;
            dstAXITranType  <= dstOp;
            dstAXIDataWidth <= dstDataWidth;
            // Source width tells the master how many cache bytes are valid
            srcAXIDataWidth <= srcDataWidth;
            numOfBytesInRd  <= rdSizeExt;
            dstStrDscrptr   <= 1'b0;
        end
        else if (launchStream)
        begin
            // Stream writes the whole descriptor, widths are not used
            strtAXIWrTran   <= 1'b1;
            dstStrtAddr     <= dstAddr;
            dstAXITranType  <= dstOp;
            dstAXIDataWidth <= '0;
            srcAXIDataWidth <= '0;
            numOfBytesInRd  <= numOfBytes;
            dstStrDscrptr   <= 1'b1;
        end
        else
        begin
            strtAXIWrTran   <= 1'b0;
            dstStrtAddr     <= '0;
            dstAXITranType  <= DST_NOP;
            dstAXIDataWidth <= '0;
            srcAXIDataWidth <= '0;
            numOfBytesInRd  <= '0;
            dstStrDscrptr   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/wrTranCtrl.sv ====
/*
 * Write-transfer controller of the DMA engine
 * Takes one queued descriptor at a time and launches its AXI write,
 * a stream-valid fetch or a no-op notification
 */
`timescale 1ns/1ps
`default_nettype none

module wrTranCtrl
    import dmaDescPkg::*;
    import wrCtrlPkg::*;
(
    input  logic        clock,
    input  logic        resetn,

    // Descriptor queue
    input  logic        reqInQueue,
    input  tranSizeT    numOfBytes,
    input  logic        strDscrptr,
    input  logic        dataValid,
    input  priLvlT      priLvl,
    input  dataWidthT   srcDataWidth,
    input  dstOpT       dstOp,
    input  dataWidthT   dstDataWidth,
    input  addrT        dstAddr,
    input  addrT        extDscrptrAddr,

    // Read-size register
    input  logic        rdSizeValid,
    input  axiTranSizeT rdSize,

    // AXI master results
    input  logic        wrTranDone,
    input  logic        wrTranError,
    input  logic        strWrTranDone,
    input  logic        strWrTranError,
    input  logic        strFetchAck,
    input  logic        strDataValid,

    // Interrupt block acks
    input  logic        wrDoneAck,
    input  logic        wrErrorAck,
    input  logic        strWrDoneAck,
    input  logic        strWrErrorAck,
    input  logic        noOpDstAck,

    // Status flags
    output logic        wrDone,
    output logic        wrError,
    output logic        strWrDone,
    output logic        strWrError,
    output logic        noOpDst,

    // Write launch toward the AXI master
    output numBeatsT    dstMaxAXINumBeats,
    output logic        dstStrDscrptr,
    output tranSizeT    numOfBytesInRd,
    output logic        strtAXIWrTran,
    output dstOpT       dstAXITranType,
    output dataWidthT   dstAXIDataWidth,
    output addrT        dstStrtAddr,
    output dataWidthT   srcAXIDataWidth,
    output logic        strFetchRdy,
    output addrT        strFetchAddr,

    output logic        strDataNReady
);

    // Launch strobes from the sequencer, never both high
    logic launchDma;
    logic launchStream;

    wrSequencer uSequencer (.*);

    wrLaunch uLaunch (.*);

    burstLimit uBurstLimit (.*);

endmodule

`default_nettype wire

// ==== sim/tbWrTranCtrl.sv ====
/*
 * Testbench for the write-transfer controller
 * Runs no-op, memory-write and stream descriptors with random fields and
 * delays, and checks launches, burst limits and status flags
 */
`timescale 1ns/1ps
`default_nettype none

`include "wrTranCtrl_cfg.svh"

module tbWrTranCtrl
    import dmaDescPkg::*;
    import wrCtrlPkg::*;
();

    localparam logic [31:0] SEED = 32'h49f9;
    localparam int NUM_DESC = 48;
    localparam int WAIT_LIMIT = 20;
    localparam int WATCHDOG_CYCLES = NUM_DESC * 40;

    localparam int FLAG_NOP = 0;
    localparam int FLAG_WR_DONE = 1;
    localparam int FLAG_WR_ERR = 2;
    localparam int FLAG_STR_DONE = 3;
    localparam int FLAG_STR_ERR = 4;

    logic clock;
    logic resetn;
    logic reqInQueue, strDscrptr, dataValid;
    tranSizeT numOfBytes;
    priLvlT priLvl;
    dataWidthT srcDataWidth, dstDataWidth;
    dstOpT dstOp;
    addrT dstAddr, extDscrptrAddr;
    logic rdSizeValid;
    axiTranSizeT rdSize;
    logic wrTranDone, wrTranError, strWrTranDone, strWrTranError;
    logic strFetchAck, strDataValid;
    logic wrDoneAck, wrErrorAck, strWrDoneAck, strWrErrorAck, noOpDstAck;
    logic wrDone, wrError, strWrDone, strWrError, noOpDst;
    numBeatsT dstMaxAXINumBeats;
    logic dstStrDscrptr, strtAXIWrTran, strFetchRdy, strDataNReady;
    tranSizeT numOfBytesInRd;
    dstOpT dstAXITranType;
    dataWidthT dstAXIDataWidth, srcAXIDataWidth;
    addrT dstStrtAddr, strFetchAddr;

    // Expected launches with one entry per launch in every queue
    addrT expAddrQ[$];
    dstOpT expOpQ[$];
    dataWidthT expSrcQ[$];
    dataWidthT expDstQ[$];
    tranSizeT expBytesQ[$];
    logic expStrQ[$];
    numBeatsT expBeatsQ[$];
    numBeatsT heldBeats = '0;

    int valueErrors = 0;
    int otherErrors = 0;

    wrTranCtrl DUT (.*);

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Reference model and compare tasks
    //////////////////////////////////////////////////
    function automatic void refLaunch(
        input  logic        isStream,
        input  priLvlT      pri,
        input  tranSizeT    bytes,
        input  axiTranSizeT rdBytes,
        input  dataWidthT   srcWidth,
        input  dataWidthT   dstWidth,
        output dataWidthT   expSrc,
        output dataWidthT   expDst,
        output tranSizeT    expBytes,
        output numBeatsT    expBeats
    );
        if (isStream)
        begin
            expSrc   = '0;
            expDst   = '0;
            expBytes = bytes;
            expBeats = `PRI0_BEATS;
        end
        else
        begin
            expSrc   = srcWidth;
            expDst   = dstWidth;
            expBytes = '0;
            expBytes[`AXI_TRAN_SIZE_WIDTH-1:0] = rdBytes;
            // Only a single set bit selects its own limit
            case (pri)
                8'b0000_0001: expBeats = `PRI0_BEATS;
                8'b0000_0010: expBeats = `PRI1_BEATS;
                8'b0000_0100: expBeats = `PRI2_BEATS;
                8'b0000_1000: expBeats = `PRI3_BEATS;
                8'b0001_0000: expBeats = `PRI4_BEATS;
                8'b0010_0000: expBeats = `PRI5_BEATS;
                8'b0100_0000: expBeats = `PRI6_BEATS;
                default:      expBeats = `PRI7_BEATS;
            endcase
        end
    endfunction

    task automatic protocolFail(input string msg);
        otherErrors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic checkLaunch(
        input string     what,
        input addrT      gotAddr,
        input addrT      expAddr,
        input dstOpT     gotOp,
        input dstOpT     expOp,
        input dataWidthT gotDst,
        input dataWidthT expDst,
        input dataWidthT gotSrc,
        input dataWidthT expSrc,
        input tranSizeT  gotBytes,
        input tranSizeT  expBytes
    );
        if (gotAddr !== expAddr || gotOp !== expOp || gotDst !== expDst ||
            gotSrc !== expSrc || gotBytes !== expBytes)
        begin
            valueErrors++;
            $display("FAIL %0t ns: %s got addr %h type %0d widths %0d/%0d bytes %0d",
                     $time, what, gotAddr, gotOp, gotDst, gotSrc, gotBytes);
            $display("    expected addr %h type %0d widths %0d/%0d bytes %0d",
                     expAddr, expOp, expDst, expSrc, expBytes);
        end
    endtask

    task automatic checkBeats(input numBeatsT got, input numBeatsT exp);
        if (got !== exp)
        begin
            valueErrors++;
            $display("FAIL %0t ns: burst limit %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            valueErrors++;
            $display("FAIL %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input addrT got, input addrT exp);
        if (got !== exp)
        begin
            valueErrors++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Registered outputs are stable at the falling edge
    always @(negedge clock)
    begin
        if (strtAXIWrTran)
        begin
            if (expAddrQ.size() == 0)
                protocolFail("write launch seen while none was expected");
            else
            begin
                checkLaunch("launch", dstStrtAddr, expAddrQ.pop_front(),
                            dstAXITranType, expOpQ.pop_front(),
                            dstAXIDataWidth, expDstQ.pop_front(),
                            srcAXIDataWidth, expSrcQ.pop_front(),
                            numOfBytesInRd, expBytesQ.pop_front());
                checkFlag("dstStrDscrptr", dstStrDscrptr, expStrQ.pop_front());
                heldBeats = expBeatsQ.pop_front();
            end
        end
        else
        begin
            checkLaunch("idle", dstStrtAddr, '0, dstAXITranType, DST_NOP,
                        dstAXIDataWidth, '0, srcAXIDataWidth, '0, numOfBytesInRd, '0);
            checkFlag("dstStrDscrptr", dstStrDscrptr, 1'b0);
        end
        checkBeats(dstMaxAXINumBeats, heldBeats);
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    task automatic pushExpected(input logic isStream);
        dataWidthT eSrc;
        dataWidthT eDst;
        tranSizeT eBytes;
        numBeatsT eBeats;
        refLaunch(isStream, priLvl, numOfBytes, rdSize, srcDataWidth, dstDataWidth,
                  eSrc, eDst, eBytes, eBeats);
        expAddrQ.push_back(dstAddr);
        expOpQ.push_back(dstOp);
        expSrcQ.push_back(eSrc);
        expDstQ.push_back(eDst);
        expBytesQ.push_back(eBytes);
        expStrQ.push_back(isStream);
        expBeatsQ.push_back(eBeats);
    endtask

    function automatic logic flagBit(input int sel);
        case (sel)
            FLAG_NOP:      return noOpDst;
            FLAG_WR_DONE:  return wrDone;
            FLAG_WR_ERR:   return wrError;
            FLAG_STR_DONE: return strWrDone;
            default:       return strWrError;
        endcase
    endfunction

    task automatic driveAck(input int sel, input logic value);
        case (sel)
            FLAG_NOP:      noOpDstAck = value;
            FLAG_WR_DONE:  wrDoneAck = value;
            FLAG_WR_ERR:   wrErrorAck = value;
            FLAG_STR_DONE: strWrDoneAck = value;
            default:       strWrErrorAck = value;
        endcase
    endtask

    // Wait for a flag and hold off the ack before retiring the descriptor
    task automatic ackFlag(input int sel, input string name);
        int waited;
        waited = 0;
        while (flagBit(sel) !== 1'b1 && waited < WAIT_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        if (flagBit(sel) !== 1'b1)
            protocolFail({name, " never rose"});
        repeat ($urandom % 6)
        begin
            @(negedge clock);
            checkFlag(name, flagBit(sel), 1'b1);
        end
        driveAck(sel, 1'b1);
        reqInQueue = 1'b0;
        @(negedge clock);
        driveAck(sel, 1'b0);
        checkFlag(name, flagBit(sel), 1'b0);
    endtask

    task automatic waitLaunch();
        int waited;
        waited = 0;
        @(negedge clock);
        while (strtAXIWrTran !== 1'b1 && waited < WAIT_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        if (strtAXIWrTran !== 1'b1)
            protocolFail("expected write launch never appeared");
    endtask

    task automatic randomDesc(input logic isStream, input logic isNop);
        numOfBytes     = $urandom;
        dstAddr        = $urandom;
        extDscrptrAddr = $urandom;
        srcDataWidth   = $urandom;
        dstDataWidth   = $urandom;
        rdSize         = $urandom;
        // Mostly one-hot with an invalid pattern now and then
        if ($urandom % 4 == 0)
            priLvl = $urandom;
        else
            priLvl = 8'd1 << ($urandom % `NUM_PRI_LVLS);
        dstOp      = isNop ? DST_NOP : dstOpT'(1 + $urandom % 3);
        strDscrptr = isNop ? ($urandom % 2 == 1) : isStream;
        dataValid  = 1'b0;
        reqInQueue = 1'b1;
    endtask

    task automatic finishWrite(input logic isStream);
        logic isErr;
        repeat ($urandom % 6) @(negedge clock);
        isErr = ($urandom % 2 == 1);
        if (isStream)
        begin
            strWrTranDone  = !isErr;
            strWrTranError = isErr;
        end
        else
        begin
            wrTranDone  = !isErr;
            wrTranError = isErr;
        end
        @(negedge clock);
        wrTranDone     = 1'b0;
        wrTranError    = 1'b0;
        strWrTranDone  = 1'b0;
        strWrTranError = 1'b0;
        if (isStream)
            ackFlag(isErr ? FLAG_STR_ERR : FLAG_STR_DONE, isErr ? "strWrError" : "strWrDone");
        else
            ackFlag(isErr ? FLAG_WR_ERR : FLAG_WR_DONE, isErr ? "wrError" : "wrDone");
    endtask

    //////////////////////////////////////////////////
    // Descriptor scenarios
    //////////////////////////////////////////////////
    task automatic runDma();
        randomDesc(1'b0, 1'b0);
        // No launch allowed before the read size is known
        repeat (1 + $urandom % 5) @(negedge clock);
        rdSize      = $urandom;
        rdSizeValid = 1'b1;
        pushExpected(1'b0);
        waitLaunch();
        rdSizeValid = 1'b0;
        finishWrite(1'b0);
    endtask

    task automatic runStreamFetch();
        logic fetchValid;
        randomDesc(1'b1, 1'b0);
        #1;
        checkFlag("strFetchRdy", strFetchRdy, 1'b1);
        checkAddr("strFetchAddr", strFetchAddr, extDscrptrAddr);
        repeat ($urandom % 6 + 1)
        begin
            @(negedge clock);
            checkFlag("strFetchRdy", strFetchRdy, 1'b1);
            checkAddr("strFetchAddr", strFetchAddr, extDscrptrAddr);
        end
        fetchValid   = ($urandom % 2 == 1);
        strFetchAck  = 1'b1;
        strDataValid = fetchValid;
        if (fetchValid)
        begin
            pushExpected(1'b1);
            waitLaunch();
            strFetchAck  = 1'b0;
            strDataValid = 1'b0;
            finishWrite(1'b1);
        end
        else
        begin
            reqInQueue = 1'b0;
            @(negedge clock);
            checkFlag("strDataNReady", strDataNReady, 1'b1);
            checkFlag("strFetchRdy", strFetchRdy, 1'b0);
            strFetchAck  = 1'b0;
            strDataValid = 1'b0;
            @(negedge clock);
            checkFlag("strDataNReady", strDataNReady, 1'b0);
        end
    endtask

    initial
    begin
        int seedValue;
        seedValue = $urandom(SEED);
        resetn = 1'b0;
        {reqInQueue, strDscrptr, dataValid, rdSizeValid} = '0;
        {numOfBytes, priLvl, srcDataWidth, dstDataWidth, rdSize} = '0;
        dstOp = DST_NOP;
        dstAddr = '0;
        extDscrptrAddr = '0;
        {wrTranDone, wrTranError, strWrTranDone, strWrTranError} = '0;
        {strFetchAck, strDataValid} = '0;
        {wrDoneAck, wrErrorAck, strWrDoneAck, strWrErrorAck, noOpDstAck} = '0;
        repeat (2) @(negedge clock);
        resetn = 1'b1;
        @(negedge clock);

        for (int i = 0; i < NUM_DESC; i++)
        begin
            case (i % 4)
                0:
                begin
                    randomDesc(1'b0, 1'b1);
                    ackFlag(FLAG_NOP, "noOpDst");
                end
                1:
                    runDma();
                2:
                begin
                    randomDesc(1'b1, 1'b0);
                    dataValid = 1'b1;
                    pushExpected(1'b1);
                    waitLaunch();
                    finishWrite(1'b1);
                end
                default:
                    runStreamFetch();
            endcase
        end

        repeat (4) @(negedge clock);
        if (expAddrQ.size() != 0)
            protocolFail("a write launch was expected but never seen");
        $display("Run over: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired before all descriptors were processed");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== wrTranCtrl.f ====
+incdir+common
common/dmaDescPkg.sv
common/wrCtrlPkg.sv
hw/wrSequencer/wrSequencer.sv
hw/burstLimit.sv
hw/wrLaunch.sv
hw/wrTranCtrl.sv
sim/tbWrTranCtrl.sv
